// File: vlog.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_dst_tracker.sv
rtl/hazard_detect.sv
rtl/forward_select.sv
rtl/hazard_ctrl_top.sv
bench/hazard_ctrl_assertions.sv
bench/hazard_ctrl_tb.sv

// File: Makefile
TOP := hazard_ctrl_tb

.PHONY: sim clean

# pass only when the testbench prints the pass line
sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f vlog.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: bench/hazard_ctrl_tb.sv
`timescale 1ns/1ps
`include "hazard_cfg.svh"

module hazard_ctrl_tb;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int SETTLE_NS      = 2;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MAX_HOLD       = 6;
    localparam int RANDOM_COUNT   = 300;

    logic         i_clk;
    logic         i_rst_n;
    reg_addr_t    i_rs_id;
    reg_addr_t    i_rt_id;
    reg_addr_t    i_reg_dst_id;
    logic         i_wb_write_id;
    logic         i_mem_read_id;
    branch_kind_t i_branch_kind_id;
    logic         o_stall;
    fwd_sel_t     o_fwd_a_sel;
    fwd_sel_t     o_fwd_b_sel;

    // reference pipeline with one entry per stage behind ID
    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    reg_addr_t ex_dst;
    logic      ex_wr;
    logic      ex_load;
    reg_addr_t mem_dst;
    logic      mem_wr;
    reg_addr_t wb_dst;
    logic      wb_wr;

    fwd_sel_t    seen_fwd_a;
    fwd_sel_t    seen_fwd_b;
    string       test_name;
    int          stall_errors;
    int          fwd_errors;
    int          directed_errors;
    int          cycle_count;
    logic [31:0] lcg_state;

    hazard_ctrl_top hazard_ctrl_top_inst (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_rs_id          (i_rs_id),
        .i_rt_id          (i_rt_id),
        .i_reg_dst_id     (i_reg_dst_id),
        .i_wb_write_id    (i_wb_write_id),
        .i_mem_read_id    (i_mem_read_id),
        .i_branch_kind_id (i_branch_kind_id),
        .o_stall          (o_stall),
        .o_fwd_a_sel      (o_fwd_a_sel),
        .o_fwd_b_sel      (o_fwd_b_sel)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // load-use on rs or rt, BEQ/BNE on any pending writer, JR on rs alone
    function automatic logic expected_stall(reg_addr_t rs, reg_addr_t rt, branch_kind_t bk);
        logic rs_busy;
        logic rt_busy;
        logic load_hit;
        rs_busy = (rs != '0) && ((ex_wr && ex_dst == rs) || (mem_wr && mem_dst == rs)
                                 || (wb_wr && wb_dst == rs));
        rt_busy = (rt != '0) && ((ex_wr && ex_dst == rt) || (mem_wr && mem_dst == rt)
                                 || (wb_wr && wb_dst == rt));
        load_hit = ex_load && (ex_dst != '0) && (ex_dst == rs || ex_dst == rt);
        if (load_hit) begin
            return 1'b1;
        end
        if (bk == `HZ_BR_RS_RT) begin
            return rs_busy || rt_busy;
        end
        if (bk == `HZ_BR_RS) begin
            return rs_busy;
        end
        return 1'b0;
    endfunction

    // the newest writer wins and r0 always reads the register file
    function automatic fwd_sel_t expected_fwd(reg_addr_t src);
        if (src == '0) begin
            return `HZ_FWD_REG;
        end
        if (mem_wr && mem_dst == src) begin
            return `HZ_FWD_MEM;
        end
        if (wb_wr && wb_dst == src) begin
            return `HZ_FWD_WB;
        end
        return `HZ_FWD_REG;
    endfunction

    task automatic reset_model();
        ex_rs   = '0;
        ex_rt   = '0;
        ex_dst  = '0;
        ex_wr   = 1'b0;
        ex_load = 1'b0;
        mem_dst = '0;
        mem_wr  = 1'b0;
        wb_dst  = '0;
        wb_wr   = 1'b0;
    endtask

    // one rising edge where a stall puts a bubble into EX
    task automatic advance_model(input logic stall);
        wb_dst  = mem_dst;
        wb_wr   = mem_wr;
        mem_dst = ex_dst;
        mem_wr  = ex_wr;
        if (stall) begin
            ex_rs   = '0;
            ex_rt   = '0;
            ex_dst  = '0;
            ex_wr   = 1'b0;
            ex_load = 1'b0;
        end else begin
            ex_rs   = i_rs_id;
            ex_rt   = i_rt_id;
            ex_dst  = i_reg_dst_id;
            ex_wr   = i_wb_write_id;
            ex_load = i_mem_read_id;
        end
    endtask

    task automatic set_idle_inputs();
        i_rs_id          = '0;
        i_rt_id          = '0;
        i_reg_dst_id     = '0;
        i_wb_write_id    = 1'b0;
        i_mem_read_id    = 1'b0;
        i_branch_kind_id = `HZ_BR_NONE;
    endtask

    task automatic check_outputs(output logic exp_stall);
        fwd_sel_t exp_a;
        fwd_sel_t exp_b;
        exp_stall  = expected_stall(i_rs_id, i_rt_id, i_branch_kind_id);
        exp_a      = expected_fwd(ex_rs);
        exp_b      = expected_fwd(ex_rt);
        seen_fwd_a = o_fwd_a_sel;
        seen_fwd_b = o_fwd_b_sel;
        assert (o_stall === exp_stall) else begin
            stall_errors++;
            $display("Fail %s: o_stall expected %0b actual %0b", test_name, exp_stall, o_stall);
        end
        assert (o_fwd_a_sel === exp_a) else begin
            fwd_errors++;
            $display("Fail %s: o_fwd_a_sel expected %b actual %b", test_name, exp_a, o_fwd_a_sel);
        end
        assert (o_fwd_b_sel === exp_b) else begin
            fwd_errors++;
            $display("Fail %s: o_fwd_b_sel expected %b actual %b", test_name, exp_b, o_fwd_b_sel);
        end
    endtask

    task automatic drive_cycle(input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t dst,
                               input logic wr, input logic ld, input branch_kind_t bk,
                               output logic dut_stall);
        logic exp_stall;
        @(negedge i_clk);
        i_rs_id          = rs;
        i_rt_id          = rt;
        i_reg_dst_id     = dst;
        i_wb_write_id    = wr;
        i_mem_read_id    = ld;
        i_branch_kind_id = bk;
        // outputs are settled well before the rising edge
        #(SETTLE_NS);
        check_outputs(exp_stall);
        dut_stall = o_stall;
        @(posedge i_clk);
        advance_model(exp_stall);
    endtask

    // present one instruction in ID and hold it while the DUT stalls
    task automatic issue_instr(input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t dst,
                               input logic wr, input logic ld, input branch_kind_t bk,
                               output int stalls);
        logic dut_stall;
        stalls = 0;
        drive_cycle(rs, rt, dst, wr, ld, bk, dut_stall);
        while (dut_stall && stalls < MAX_HOLD) begin
            stalls++;
            drive_cycle(rs, rt, dst, wr, ld, bk, dut_stall);
        end
        assert (!dut_stall) else begin
            directed_errors++;
            $display("%s: instruction still held in ID after %0d cycles", test_name, stalls);
        end
    endtask

    task automatic flush_pipe();
        int n;
        repeat (3) issue_instr(5'd0, 5'd0, 5'd0, 1'b0, 1'b0, `HZ_BR_NONE, n);
    endtask

    task automatic check_stall_count(input int exp, input int act);
        assert (act == exp) else begin
            directed_errors++;
            $display("Fail %s: stall cycles expected %0d actual %0d", test_name, exp, act);
        end
    endtask

    task automatic check_fwd(input fwd_sel_t exp_a, input fwd_sel_t exp_b);
        assert (seen_fwd_a == exp_a && seen_fwd_b == exp_b) else begin
            directed_errors++;
            $display("Fail %s: forward selects expected %b/%b actual %b/%b", test_name,
                     exp_a, exp_b, seen_fwd_a, seen_fwd_b);
        end
    endtask

    // the given ID operands stay on the inputs while reset is low
    task automatic apply_reset(input int cycles, input reg_addr_t held_rs,
                               input reg_addr_t held_rt, input branch_kind_t held_bk);
        @(negedge i_clk);
        i_rst_n = 1'b0;
        set_idle_inputs();
        i_rs_id          = held_rs;
        i_rt_id          = held_rt;
        i_branch_kind_id = held_bk;
        repeat (cycles) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        set_idle_inputs();
        reset_model();
    endtask

    task automatic load_use_stall();
        int n;
        test_name = "load_use";
        flush_pipe();
        issue_instr(5'd1, 5'd0, 5'd5, 1'b1, 1'b1, `HZ_BR_NONE, n);
        issue_instr(5'd5, 5'd2, 5'd6, 1'b1, 1'b0, `HZ_BR_NONE, n);
        check_stall_count(1, n);
        flush_pipe();
        // load into r0 is never a hazard
        issue_instr(5'd1, 5'd0, 5'd0, 1'b1, 1'b1, `HZ_BR_NONE, n);
        issue_instr(5'd0, 5'd3, 5'd6, 1'b1, 1'b0, `HZ_BR_NONE, n);
        check_stall_count(0, n);
    endtask

    task automatic beq_pending_writer();
        int n;
        int gap;
        test_name = "beq_pending";
        for (gap = 0; gap < 3; gap++) begin
            flush_pipe();
            issue_instr(5'd1, 5'd2, 5'd7, 1'b1, 1'b0, `HZ_BR_NONE, n);
            repeat (gap) issue_instr(5'd0, 5'd0, 5'd0, 1'b0, 1'b0, `HZ_BR_NONE, n);
            issue_instr(5'd1, 5'd7, 5'd0, 1'b0, 1'b0, `HZ_BR_RS_RT, n);
            check_stall_count(3 - gap, n);
        end
    endtask

    task automatic jr_rs_only();
        int n;
        test_name = "jr_rs_only";
        flush_pipe();
        issue_instr(5'd1, 5'd2, 5'd9, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd9, 5'd0, 5'd0, 1'b0, 1'b0, `HZ_BR_RS, n);
        check_stall_count(3, n);
        flush_pipe();
        issue_instr(5'd1, 5'd2, 5'd9, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd1, 5'd9, 5'd0, 1'b0, 1'b0, `HZ_BR_RS, n);
        check_stall_count(0, n);
    endtask

    // the nop after each dependent samples the selects while it sits in EX
    task automatic forward_priority();
        int n;
        test_name = "forward_priority";
        flush_pipe();
        issue_instr(5'd1, 5'd2, 5'd4, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd2, 5'd3, 5'd4, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd4, 5'd4, 5'd5, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd0, 5'd0, 5'd0, 1'b0, 1'b0, `HZ_BR_NONE, n);
        check_fwd(`HZ_FWD_MEM, `HZ_FWD_MEM);
        issue_instr(5'd2, 5'd3, 5'd6, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd0, 5'd0, 5'd0, 1'b0, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd6, 5'd1, 5'd7, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd0, 5'd0, 5'd0, 1'b0, 1'b0, `HZ_BR_NONE, n);
        check_fwd(`HZ_FWD_WB, `HZ_FWD_REG);
        flush_pipe();
        issue_instr(5'd4, 5'd4, 5'd5, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd0, 5'd0, 5'd0, 1'b0, 1'b0, `HZ_BR_NONE, n);
        check_fwd(`HZ_FWD_REG, `HZ_FWD_REG);
    endtask

    task automatic random_sequence();
        logic [31:0]  r;
        logic [1:0]   k;
        reg_addr_t    rs;
        reg_addr_t    rt;
        reg_addr_t    dst;
        branch_kind_t bk;
        logic         ld;
        logic         wr;
        int           n;
        int           i;
        test_name = "random_sequence";
        for (i = 0; i < RANDOM_COUNT; i++) begin
            r   = lcg_next();
            // registers r0..r7 only so hazards are frequent
            rs  = {2'b00, r[10:8]};
            rt  = {2'b00, r[14:12]};
            dst = {2'b00, r[18:16]};
            k   = r[21:20];
            bk  = (k == 2'b11) ? `HZ_BR_NONE : k;
            ld  = (bk == `HZ_BR_NONE) && (r[24:23] == 2'b00);
            wr  = (bk == `HZ_BR_NONE) && (ld || r[25]);
            issue_instr(rs, rt, dst, wr, ld, bk, n);
        end
    endtask

    task automatic reset_mid_flight();
        int n;
        test_name = "reset_mid_flight";
        issue_instr(5'd1, 5'd2, 5'd3, 1'b1, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd2, 5'd1, 5'd3, 1'b1, 1'b1, `HZ_BR_NONE, n);
        // a BEQ on r3 waits in ID while reset clears the writers ahead of it
        apply_reset(2, 5'd3, 5'd3, `HZ_BR_RS_RT);
        issue_instr(5'd3, 5'd3, 5'd0, 1'b0, 1'b0, `HZ_BR_RS_RT, n);
        check_stall_count(0, n);
        issue_instr(5'd3, 5'd3, 5'd0, 1'b0, 1'b0, `HZ_BR_NONE, n);
        issue_instr(5'd0, 5'd0, 5'd0, 1'b0, 1'b0, `HZ_BR_NONE, n);
        check_fwd(`HZ_FWD_REG, `HZ_FWD_REG);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        int total;
        i_rst_n         = 1'b0;
        stall_errors    = 0;
        fwd_errors      = 0;
        directed_errors = 0;
        lcg_state       = 32'hd32e;
        test_name       = "reset";
        set_idle_inputs();
        reset_model();
        apply_reset(RESET_CYCLES, 5'd0, 5'd0, `HZ_BR_NONE);
        load_use_stall();
        beq_pending_writer();
        jr_rs_only();
        forward_priority();
        random_sequence();
        reset_mid_flight();
        total = stall_errors + fwd_errors + directed_errors;
        $display("errors: %0d (stall %0d, forward %0d, directed %0d)", total, stall_errors,
                 fwd_errors, directed_errors);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/hazard_ctrl_assertions.sv
`timescale 1ns/1ps

module hazard_ctrl_assertions (
    input logic               i_clk,
    input logic               i_rst_n,
    input isa_pkg::reg_addr_t i_rs_id,
    input isa_pkg::reg_addr_t i_rt_id,
    input isa_pkg::reg_addr_t i_reg_dst_ex,
    input logic               i_wb_write_ex,
    input logic               i_mem_read_ex,
    input logic               i_stall,
    input pipe_pkg::fwd_sel_t i_fwd_a_sel,
    input pipe_pkg::fwd_sel_t i_fwd_b_sel
);

    logic load_use;

    // load in EX whose destination is read by the instruction in ID
    assign load_use = i_mem_read_ex && (i_reg_dst_ex != '0)
                   && (i_reg_dst_ex == i_rs_id || i_reg_dst_ex == i_rt_id);

    // from the second reset cycle on the tracker holds only bubbles
    stall_low_in_reset: assert property (@(posedge i_clk)
        (!i_rst_n && $past(!i_rst_n)) |-> !i_stall)
        else $error("stall raised while in reset");

    fwd_code_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_fwd_a_sel != 2'b11) && (i_fwd_b_sel != 2'b11))
        else $error("forward select holds the unused code");

    // the stalled dependent leaves a bubble behind the load
    load_use_stalls: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        load_use |=> (!i_wb_write_ex && !i_mem_read_ex))
        else $error("load-use match did not put a bubble into EX");

endmodule

bind hazard_ctrl_top hazard_ctrl_assertions hazard_ctrl_assertions_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_rs_id       (i_rs_id),
    .i_rt_id       (i_rt_id),
    .i_reg_dst_ex  (reg_dst_ex),
    .i_wb_write_ex (wb_write_ex),
    .i_mem_read_ex (mem_read_ex),
    .i_stall       (o_stall),
    .i_fwd_a_sel   (o_fwd_a_sel),
    .i_fwd_b_sel   (o_fwd_b_sel)
);

// File: rtl/hazard_ctrl_top.sv
`timescale 1ns/1ps

module hazard_ctrl_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // decoded fields of the instruction in ID
    input  isa_pkg::reg_addr_t    i_rs_id,
    input  isa_pkg::reg_addr_t    i_rt_id,
    input  isa_pkg::reg_addr_t    i_reg_dst_id,
    input  logic                  i_wb_write_id,
    input  logic                  i_mem_read_id,
    input  isa_pkg::branch_kind_t i_branch_kind_id,

    // hold PC and IF/ID while high
    output logic                  o_stall,
    output pipe_pkg::fwd_sel_t    o_fwd_a_sel,
    output pipe_pkg::fwd_sel_t    o_fwd_b_sel
);

    import isa_pkg::*;

    reg_addr_t rs_ex;
    reg_addr_t rt_ex;
    reg_addr_t reg_dst_ex;
    reg_addr_t reg_dst_mem;
    reg_addr_t reg_dst_wb;
    logic      wb_write_ex;
    logic      wb_write_mem;
    logic      wb_write_wb;
    logic      mem_read_ex;

    // the stall feeds back so EX takes a bubble
    stage_dst_tracker stage_dst_tracker_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (o_stall),
        .i_rs_id        (i_rs_id),
        .i_rt_id        (i_rt_id),
        .i_reg_dst_id   (i_reg_dst_id),
        .i_wb_write_id  (i_wb_write_id),
        .i_mem_read_id  (i_mem_read_id),
        .o_rs_ex        (rs_ex),
        .o_rt_ex        (rt_ex),
        .o_reg_dst_ex   (reg_dst_ex),
        .o_wb_write_ex  (wb_write_ex),
        .o_mem_read_ex  (mem_read_ex),
        .o_reg_dst_mem  (reg_dst_mem),
        .o_wb_write_mem (wb_write_mem),
        .o_reg_dst_wb   (reg_dst_wb),
        .o_wb_write_wb  (wb_write_wb)
    );

    hazard_detect hazard_detect_inst (
        .i_rs_id          (i_rs_id),
        .i_rt_id          (i_rt_id),
        .i_branch_kind_id (i_branch_kind_id),
        .i_reg_dst_ex     (reg_dst_ex),
        .i_reg_dst_mem    (reg_dst_mem),
        .i_reg_dst_wb     (reg_dst_wb),
        .i_wb_write_ex    (wb_write_ex),
        .i_wb_write_mem   (wb_write_mem),
        .i_wb_write_wb    (wb_write_wb),
        .i_mem_read_ex    (mem_read_ex),
        .o_stall          (o_stall)
    );

    forward_select forward_select_inst (
        .i_rs_ex        (rs_ex),
        .i_rt_ex        (rt_ex),
        .i_reg_dst_mem  (reg_dst_mem),
        .i_reg_dst_wb   (reg_dst_wb),
        .i_wb_write_mem (wb_write_mem),
        .i_wb_write_wb  (wb_write_wb),
        .o_fwd_a_sel    (o_fwd_a_sel),
        .o_fwd_b_sel    (o_fwd_b_sel)
    );

endmodule

// File: rtl/forward_select.sv
`timescale 1ns/1ps
`include "hazard_cfg.svh"

module forward_select (
    // operands of the instruction in EX
    input  isa_pkg::reg_addr_t i_rs_ex,
    input  isa_pkg::reg_addr_t i_rt_ex,

    // writers ahead of it
    input  isa_pkg::reg_addr_t i_reg_dst_mem,
    input  isa_pkg::reg_addr_t i_reg_dst_wb,
    input  logic               i_wb_write_mem,
    input  logic               i_wb_write_wb,

    output pipe_pkg::fwd_sel_t o_fwd_a_sel,
    output pipe_pkg::fwd_sel_t o_fwd_b_sel
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // MEM holds the newer value, so it wins over WB
    function automatic fwd_sel_t pick_source(
        input reg_addr_t src,
        input reg_addr_t dst_mem,
        input logic      wr_mem,
        input reg_addr_t dst_wb,
        input logic      wr_wb
    );
        if (wr_mem && (dst_mem != '0) && (dst_mem == src)) begin
            pick_source = `HZ_FWD_MEM;
        end else if (wr_wb && (dst_wb != '0) && (dst_wb == src)) begin
            pick_source = `HZ_FWD_WB;
        end else begin
            pick_source = `HZ_FWD_REG;
        end
    endfunction

    // operand A comes from rs
    assign o_fwd_a_sel = pick_source(i_rs_ex, i_reg_dst_mem, i_wb_write_mem,
                                     i_reg_dst_wb, i_wb_write_wb);

    // operand B comes from rt
    assign o_fwd_b_sel = pick_source(i_rt_ex, i_reg_dst_mem, i_wb_write_mem,
                                     i_reg_dst_wb, i_wb_write_wb);

endmodule

// File: rtl/hazard_detect.sv
`timescale 1ns/1ps
`include "hazard_cfg.svh"

module hazard_detect (
    // operands and branch kind of the instruction in ID
    input  isa_pkg::reg_addr_t    i_rs_id,
    input  isa_pkg::reg_addr_t    i_rt_id,
    input  isa_pkg::branch_kind_t i_branch_kind_id,

    // pending writers further down the pipe
    input  isa_pkg::reg_addr_t    i_reg_dst_ex,
    input  isa_pkg::reg_addr_t    i_reg_dst_mem,
    input  isa_pkg::reg_addr_t    i_reg_dst_wb,
    input  logic                  i_wb_write_ex,
    input  logic                  i_wb_write_mem,
    input  logic                  i_wb_write_wb,
    input  logic                  i_mem_read_ex,

    output logic                  o_stall
);

    import isa_pkg::*;

    // a stage that writes src, r0 never counts as a match
    function automatic logic writes_src(
        input reg_addr_t src,
        input reg_addr_t dst,
        input logic      wr
    );
        writes_src = wr && (dst != '0) && (dst == src);
    endfunction

    logic load_use;
    logic rs_pending;
    logic rt_pending;
    logic branch_stall;

    // load in EX whose data is not ready until the end of MEM
    assign load_use = writes_src(i_rs_id, i_reg_dst_ex, i_mem_read_ex)
                   || writes_src(i_rt_id, i_reg_dst_ex, i_mem_read_ex);

    // the branch compare sits in ID, so it waits for the writer to retire
    assign rs_pending = writes_src(i_rs_id, i_reg_dst_ex,  i_wb_write_ex)
                     || writes_src(i_rs_id, i_reg_dst_mem, i_wb_write_mem)
                     || writes_src(i_rs_id, i_reg_dst_wb,  i_wb_write_wb);

    assign rt_pending = writes_src(i_rt_id, i_reg_dst_ex,  i_wb_write_ex)
                     || writes_src(i_rt_id, i_reg_dst_mem, i_wb_write_mem)
                     || writes_src(i_rt_id, i_reg_dst_wb,  i_wb_write_wb);

    always_comb begin
        case (i_branch_kind_id)
            `HZ_BR_RS_RT: begin
                branch_stall = rs_pending || rt_pending;
            end
            // JR and JALR ignore rt
            `HZ_BR_RS: begin
                branch_stall = rs_pending;
            end
            `HZ_BR_NONE: begin
                branch_stall = 1'b0;
            end
            default: begin
                branch_stall = 1'b0;
            end
        endcase
    end

    assign o_stall = load_use || branch_stall;

endmodule

// File: rtl/stage_dst_tracker.sv
`timescale 1ns/1ps

module stage_dst_tracker (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_stall,

    // fields of the instruction in ID
    input  isa_pkg::reg_addr_t i_rs_id,
    input  isa_pkg::reg_addr_t i_rt_id,
    input  isa_pkg::reg_addr_t i_reg_dst_id,
    input  logic              i_wb_write_id,
    input  logic              i_mem_read_id,

    // EX stage
    output isa_pkg::reg_addr_t o_rs_ex,
    output isa_pkg::reg_addr_t o_rt_ex,
    output isa_pkg::reg_addr_t o_reg_dst_ex,
    output logic              o_wb_write_ex,
    output logic              o_mem_read_ex,

    // MEM and WB stages
    output isa_pkg::reg_addr_t o_reg_dst_mem,
    output logic              o_wb_write_mem,
    output isa_pkg::reg_addr_t o_reg_dst_wb,
    output logic              o_wb_write_wb
);

    import isa_pkg::*;

    // register fields per stage
    reg_addr_t rs_ex;
    reg_addr_t rt_ex;
    reg_addr_t reg_dst_ex;
    reg_addr_t reg_dst_mem;
    reg_addr_t reg_dst_wb;

    // control per stage
    logic wb_write_ex;
    logic mem_read_ex;
    logic wb_write_mem;
    logic wb_write_wb;

    // control bits, a stall turns the EX entry into a bubble
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wb_write_ex  <= 1'b0;
            mem_read_ex  <= 1'b0;
            wb_write_mem <= 1'b0;
            wb_write_wb  <= 1'b0;
        end else begin
            wb_write_ex  <= i_stall ? 1'b0 : i_wb_write_id;
            mem_read_ex  <= i_stall ? 1'b0 : i_mem_read_id;
            wb_write_mem <= wb_write_ex;
            wb_write_wb  <= wb_write_mem;
        end
    end

    // register numbers, a bubble carries r0 in every field
    always_ff @(posedge i_clk) begin
        if (i_stall) begin
            rs_ex      <= '0;
            rt_ex      <= '0;
            reg_dst_ex <= '0;
        end else begin
            rs_ex      <= i_rs_id;
            rt_ex      <= i_rt_id;
            reg_dst_ex <= i_reg_dst_id;
        end
        reg_dst_mem <= reg_dst_ex;
        reg_dst_wb  <= reg_dst_mem;
    end

    assign o_rs_ex        = rs_ex;
    assign o_rt_ex        = rt_ex;
    assign o_reg_dst_ex   = reg_dst_ex;
    assign o_wb_write_ex  = wb_write_ex;
    assign o_mem_read_ex  = mem_read_ex;
    assign o_reg_dst_mem  = reg_dst_mem;
    assign o_wb_write_mem = wb_write_mem;
    assign o_reg_dst_wb   = reg_dst_wb;
    assign o_wb_write_wb  = wb_write_wb;

endmodule

// File: rtl/pipe_pkg.sv
`include "hazard_cfg.svh"

package pipe_pkg;

    // forwarding mux select for one ALU operand in EX
    // values are the HZ_FWD_* codes of the config header
    typedef logic [`HZ_FWD_SEL_W-1:0] fwd_sel_t;

endpackage

// File: rtl/isa_pkg.sv
`include "hazard_cfg.svh"

package isa_pkg;

    // register number as found in the rs, rt and rd fields
    typedef logic [`HZ_REG_ADDR_W-1:0] reg_addr_t;

    // branch kind from the decoder
    // values are the HZ_BR_* codes of the config header
    typedef logic [`HZ_BR_KIND_W-1:0] branch_kind_t;

endpackage

// File: rtl/hazard_cfg.svh
`ifndef HAZARD_CFG_SVH
`define HAZARD_CFG_SVH

// register file addressing, 32 registers with r0 hardwired to zero
`define HZ_REG_ADDR_W 5

// branch kind decoded in ID
`define HZ_BR_KIND_W 2

// no register branch
`define HZ_BR_NONE  2'b00
// BEQ and BNE read rs and rt
`define HZ_BR_RS_RT 2'b01
// JR and JALR read rs only
`define HZ_BR_RS    2'b10

// forwarding source for an EX operand
`define HZ_FWD_SEL_W 2

// value from the register file read in ID
`define HZ_FWD_REG 2'b00
// ALU result held in the MEM stage
`define HZ_FWD_MEM 2'b01
// write-back value held in the WB stage
`define HZ_FWD_WB  2'b10

`endif
